// File: flist.f
+incdir+src
src/rv_pkg.sv
src/idu.sv
src/regfile.sv
src/exu_alu.sv
src/exu_pc.sv
src/lsu.sv
src/rv_core.sv
bench/clk_gen.sv
bench/rv_core_properties.sv
bench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_rv_core \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: bench/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module tb_rv_core;

    localparam int MEM_WORDS = 256;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic        clk;
    logic        rst_n;
    logic        reset_req;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wmask;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halt;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS] = '{default: 32'h0};
    logic [31:0] dmem_init [MEM_WORDS];
    logic [31:0] prog [$];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;
    int cycle_limit  = 16; // initial reset

    clk_gen clk_gen_i (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    rv_core rv_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    // ------------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------------
    assign inst       = imem[inst_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (reset_req) begin
            for (int k = 0; k < MEM_WORDS; k++) begin
                dmem[k] <= dmem_init[k]; // image loaded while reset is held
            end
        end else if (dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OP_REG};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input int rs2, input int rs1,
                                           input int imm);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), f3, v[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int imm);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), `OP_JAL};
    endfunction

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic clear_data();
        for (int k = 0; k < MEM_WORDS; k++) dmem_init[k] = 32'h0;
        prog.delete();
    endtask

    // Load the program, reset the core, then wait for halt or a stuck PC
    task automatic run_program(input int loops, output bit halted);
        logic [31:0] last;
        int          same;
        bit          done;
        @(negedge clk);
        reset_req = 1'b1;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = (k < prog.size()) ? prog[k] : 32'h0;
        end
        cycle_limit += (prog.size() + loops) * 4;
        @(posedge rst_n);
        reset_req = 1'b0;
        halted = 1'b0;
        done   = 1'b0;
        same   = 0;
        last   = inst_addr;
        while (!done) begin
            @(negedge clk);
            if (halt) begin
                halted = 1'b1;
                done   = 1'b1;
            end else begin
                same = (inst_addr == last) ? same + 1 : 0;
                last = inst_addr;
                if (same >= 2) done = 1'b1;
            end
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_halt(input string test, input bit halted);
        if (!halted) begin
            $display("%s: program stopped without reaching ebreak", test);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%-8s ok", test);
        end else begin
            tests_failed++;
            $display("%-8s fail", test);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic arith_ops();
        logic [31:0] a, b, se_a, se_b, se_c;
        logic [31:0] expv [10];
        logic [11:0] ia, ib, ic;
        logic [4:0]  sh;
        string       names [10];
        bit          halted;
        int          e0;
        e0 = errors;
        a  = $urandom | 32'h8000_0000; // Sign bit set for srai and sltu
        b  = $urandom;
        ia = 12'($urandom);
        ib = 12'($urandom);
        ic = 12'($urandom);
        sh = 5'($urandom);
        se_a = {{20{ia[11]}}, ia};
        se_b = {{20{ib[11]}}, ib};
        se_c = {{20{ic[11]}}, ic};
        expv[0] = a + se_a;
        expv[1] = {31'b0, a < se_b}; // unsigned compare
        expv[2] = a & se_c;
        expv[3] = 32'($signed(a) >>> sh);
        expv[4] = a + b;
        expv[5] = a - b;
        expv[6] = a << b[4:0];
        expv[7] = {31'b0, a < b};
        expv[8] = a ^ b;
        expv[9] = a | b;
        names = '{"addi", "sltiu", "andi", "srai", "add", "sub", "sll", "sltu", "xor", "or"};
        clear_data();
        dmem_init[0] = a;
        dmem_init[1] = b;
        emit(i_type(0, 0, 3'b010, 1, `OP_LOAD));
        emit(i_type(4, 0, 3'b010, 2, `OP_LOAD));
        emit(i_type(int'(ia), 1, 3'b000, 3, `OP_IMM));
        emit(i_type(int'(ib), 1, 3'b011, 4, `OP_IMM));
        emit(i_type(int'(ic), 1, 3'b111, 5, `OP_IMM));
        emit(i_type(int'({7'b0100000, sh}), 1, 3'b101, 6, `OP_IMM));
        emit(r_type(7'b0000000, 2, 1, 3'b000, 7));
        emit(r_type(7'b0100000, 2, 1, 3'b000, 8));
        emit(r_type(7'b0000000, 2, 1, 3'b001, 9));
        emit(r_type(7'b0000000, 2, 1, 3'b011, 10));
        emit(r_type(7'b0000000, 2, 1, 3'b100, 11));
        emit(r_type(7'b0000000, 2, 1, 3'b110, 12));
        for (int k = 0; k < 10; k++) emit(s_type(3'b010, 3 + k, 0, 64 + 4 * k));
        emit(EBREAK);
        run_program(0, halted);
        expect_halt("arith", halted);
        for (int k = 0; k < 10; k++) check_word(names[k], dmem[16 + k], expv[k]);
        report_test("arith", e0);
    endtask

    task automatic branch_loop();
        int n;
        bit halted;
        int e0;
        e0 = errors;
        n  = 2 + int'($urandom % 7);
        clear_data();
        emit(i_type(n, 0, 3'b000, 1, `OP_IMM));   // 0: loop bound
        emit(i_type(0, 0, 3'b000, 2, `OP_IMM));   // 4
        emit(i_type(1, 2, 3'b000, 2, `OP_IMM));   // 8: loop body
        emit(b_type(3'b001, 2, 1, -4));           // 12: bne back to 8
        emit(b_type(3'b000, 2, 1, 8));            // 16: beq taken to 24
        emit(i_type(100, 2, 3'b000, 2, `OP_IMM)); // 20: skipped
        emit(s_type(3'b010, 2, 0, 0));            // 24
        emit(b_type(3'b000, 1, 0, 8));            // 28: beq not taken
        emit(i_type(7, 0, 3'b000, 3, `OP_IMM));   // 32
        emit(s_type(3'b010, 3, 0, 4));            // 36
        emit(EBREAK);
        run_program(2 * n, halted);
        expect_halt("branch", halted);
        check_word("loop_count", dmem[0], 32'(n));
        check_word("fallthrough", dmem[1], 32'd7);
        report_test("branch", e0);
    endtask

    task automatic jump_links();
        bit halted;
        int e0;
        e0 = errors;
        clear_data();
        emit(j_type(1, 12));                          // 0: jal to 12
        emit(i_type(1, 0, 3'b000, 5, `OP_IMM));       // 4
        emit(i_type(2, 0, 3'b000, 5, `OP_IMM));       // 8
        emit(s_type(3'b010, 1, 0, 0));                // 12
        emit(i_type(33, 0, 3'b000, 2, `OP_IMM));      // 16: odd base
        emit(i_type(0, 2, 3'b000, 3, `OP_JALR));      // 20: lands on 32
        emit(i_type(9, 0, 3'b000, 6, `OP_IMM));       // 24
        emit(i_type(9, 0, 3'b000, 6, `OP_IMM));       // 28
        emit(s_type(3'b010, 3, 0, 4));                // 32
        emit(s_type(3'b010, 6, 0, 8));                // 36
        emit(i_type(48, 0, 3'b000, 4, `OP_IMM));      // 40
        emit(i_type(5, 4, 3'b000, 7, `OP_JALR));      // 44: odd offset, lands on 52
        emit(i_type(1, 0, 3'b000, 8, `OP_IMM));       // 48
        emit(s_type(3'b010, 7, 0, 12));               // 52
        emit(s_type(3'b010, 8, 0, 16));               // 56
        emit(s_type(3'b010, 5, 0, 20));               // 60
        emit(EBREAK);
        run_program(0, halted);
        expect_halt("jump", halted);
        check_word("jal_link", dmem[0], 32'd4);
        check_word("jalr_link", dmem[1], 32'd24);
        check_word("jalr_skip", dmem[2], 32'd0);
        check_word("jalr_odd_link", dmem[3], 32'd48);
        check_word("jalr_odd_skip", dmem[4], 32'd0);
        check_word("jal_skip", dmem[5], 32'd0);
        report_test("jump", e0);
    endtask

    task automatic load_store();
        logic [31:0] r1, r2, w4;
        bit          halted;
        int          e0;
        e0 = errors;
        r1 = $urandom;
        r2 = $urandom;
        w4 = {r2[15:0], r1[15:0]};
        clear_data();
        dmem_init[0] = r1;
        dmem_init[1] = r2;
        emit(i_type(0, 0, 3'b010, 1, `OP_LOAD));
        emit(i_type(4, 0, 3'b010, 2, `OP_LOAD));
        emit(s_type(3'b001, 1, 0, 16)); // low half of word 4
        emit(s_type(3'b001, 2, 0, 22)); // high half of word 5
        emit(s_type(3'b001, 2, 0, 18)); // high half of word 4
        emit(s_type(3'b010, 1, 0, 24));
        emit(i_type(16, 0, 3'b010, 3, `OP_LOAD));
        emit(s_type(3'b010, 3, 0, 32));
        for (int k = 0; k < 4; k++) begin
            emit(i_type(24 + k, 0, 3'b100, 4 + k, `OP_LOAD));
            emit(s_type(3'b010, 4 + k, 0, 36 + 4 * k));
        end
        emit(EBREAK);
        run_program(0, halted);
        expect_halt("mem", halted);
        check_word("sh_both", dmem[4], w4);
        check_word("sh_high", dmem[5], {r2[15:0], 16'h0});
        check_word("sw", dmem[6], r1);
        check_word("lw", dmem[8], w4);
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("lbu_%0d", k), dmem[9 + k], {24'h0, r1[8*k +: 8]});
        end
        report_test("mem", e0);
    endtask

    task automatic auipc_offset();
        logic [19:0] u;
        bit          halted;
        int          e0;
        e0 = errors;
        u  = 20'($urandom);
        clear_data();
        emit(s_type(3'b010, 0, 0, 4)); // Store at reset PC, dmem_we held low in reset
        emit(i_type(0, 0, 3'b000, 0, `OP_IMM));
        emit({u, 5'd1, `OP_AUIPC}); // at address 8
        emit(s_type(3'b010, 1, 0, 0));
        emit(EBREAK);
        run_program(0, halted);
        expect_halt("auipc", halted);
        check_word("auipc", dmem[0], 32'd8 + {u, 12'h0});
        report_test("auipc", e0);
    endtask

    task automatic halt_and_hold();
        bit halted;
        int e0;
        e0 = errors;
        clear_data();
        emit(i_type(32'h55, 0, 3'b000, 1, `OP_IMM));
        emit(s_type(3'b010, 1, 0, 0));
        emit(EBREAK);
        emit(s_type(3'b010, 1, 0, 4)); // must never retire
        run_program(0, halted);
        expect_halt("ebreak", halted);
        repeat (4) @(negedge clk);
        check_word("halt", 32'(halt), 32'd1);
        check_word("store_before", dmem[0], 32'h55);
        check_word("store_after", dmem[1], 32'h0);
        report_test("ebreak", e0);

        e0 = errors;
        clear_data();
        emit(i_type(32'h33, 0, 3'b000, 1, `OP_IMM));
        emit(s_type(3'b010, 1, 0, 0));
        emit(32'hffff_ffff);            // unknown word at 8
        emit(s_type(3'b010, 1, 0, 4));
        emit(EBREAK);
        run_program(0, halted);
        if (halted) begin
            $display("unknown: core halted instead of holding");
            errors++;
        end
        repeat (4) @(negedge clk);
        check_word("inst_addr", inst_addr, 32'd8);
        check_word("halt", 32'(halt), 32'd0);
        check_word("store_before", dmem[0], 32'h33);
        check_word("store_after", dmem[1], 32'h0);
        report_test("unknown", e0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        reset_req = 1'b0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k]      = 32'h0;
            dmem_init[k] = 32'h0;
        end
        void'($urandom(32'h9b23));
        @(posedge rst_n);

        arith_ops();
        branch_loop();
        jump_links();
        load_store();
        auipc_offset();
        halt_and_hold();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/rv_core_properties.sv
`timescale 1ns/10ps

module rv_core_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        dmem_we,
    input logic        halt,
    input logic [31:0] pc
);

    // Core stays quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!dmem_we && !halt))
        else $error("dmem_we or halt high during reset");

    // Halt is sticky
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
        else $error("halt fell without reset");

    // PC frozen once halted
    a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) halt |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

bind rv_core rv_core_properties rv_core_properties_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .dmem_we (dmem_we),
    .halt    (halt),
    .pc      (pc)
);

// File: bench/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int HALF_PERIOD = 50
) (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Low for two rising edges, released on a falling edge
    always begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge reset_req); // next reset pulse on request
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`ISA_WIDTH-1:0] inst_addr,
    input  logic [`ISA_WIDTH-1:0] inst,
    output logic [`ISA_WIDTH-1:0] dmem_addr,
    output logic [`ISA_WIDTH-1:0] dmem_wdata,
    output logic [3:0]            dmem_wmask,
    output logic                  dmem_we,
    input  logic [`ISA_WIDTH-1:0] dmem_rdata,
    output logic                  halt
);

    import rv_pkg::*;

    logic [`ISA_WIDTH-1:0] pc;
    logic [`ISA_WIDTH-1:0] pc_in;
    logic                  pc_w_en;
    logic                  commit;

    inst_num_e             inst_num;
    inst_type_e            inst_type;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic [`IMM_WIDTH-1:0] imm;

    logic [`ISA_WIDTH-1:0] src1;
    logic [`ISA_WIDTH-1:0] src2;
    logic [`ISA_WIDTH-1:0] alu_result;
    logic [`ISA_WIDTH-1:0] mem_r;
    logic                  dmem_store;
    logic                  rd_we;
    logic [`ISA_WIDTH-1:0] rd_data;

    assign inst_addr = pc;
    assign commit    = pc_w_en && !halt && rst_n; // nothing retires in reset or once halted

    // ------------------------------------------------------------------------
    // PC and halt flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= `RESET_PC;
            halt <= 1'b0;
        end else if (commit) begin
            pc <= pc_in;
            if (inst_num == INST_EBREAK) halt <= 1'b1; // sticky
        end
    end

    // ------------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------------
    assign rd_we   = commit && (inst_type inside {R, I, U, J}) && (inst_num != INST_EBREAK);
    assign dmem_we = commit && dmem_store;

    always_comb begin
        case (inst_num)
            INST_JAL, INST_JALR: rd_data = pc + `ISA_WIDTH'd4; // Link address
            INST_LW, INST_LBU:   rd_data = mem_r;
            default:             rd_data = alu_result;
        endcase
    end

    idu idu_i (
        .inst      (inst),
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .src1    (src1),
        .src2    (src2)
    );

    exu_alu exu_alu_i (
        .inst_num   (inst_num),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .pc         (pc),
        .alu_result (alu_result)
    );

    exu_pc exu_pc_i (
        .inst_num   (inst_num),
        .inst_type  (inst_type),
        .imm        (imm),
        .pc_out     (pc),
        .src1       (src1),
        .alu_result (alu_result),
        .pc_in      (pc_in),
        .pc_w_en    (pc_w_en)
    );

    lsu lsu_i (
        .inst_num   (inst_num),
        .alu_result (alu_result),
        .src2       (src2),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_store (dmem_store),
        .dmem_rdata (dmem_rdata),
        .mem_r      (mem_r)
    );

endmodule

// File: src/lsu.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module lsu (
    input  rv_pkg::inst_num_e     inst_num,
    input  logic [`ISA_WIDTH-1:0] alu_result,
    input  logic [`ISA_WIDTH-1:0] src2,
    output logic [`ISA_WIDTH-1:0] dmem_addr,
    output logic [`ISA_WIDTH-1:0] dmem_wdata,
    output logic [3:0]            dmem_wmask,
    output logic                  dmem_store,
    input  logic [`ISA_WIDTH-1:0] dmem_rdata,
    output logic [`ISA_WIDTH-1:0] mem_r
);

    import rv_pkg::*;

    logic [1:0] lane;
    logic [7:0] rd_byte;

    assign lane      = alu_result[1:0];
    assign dmem_addr = {alu_result[`ISA_WIDTH-1:2], 2'b00}; // Word aligned

    // ------------------------------------------------------------------------
    // Store side
    // ------------------------------------------------------------------------
    assign dmem_store = (inst_num == INST_SH) || (inst_num == INST_SW);
    assign dmem_wdata = (inst_num == INST_SH) ? {2{src2[15:0]}} : src2;

    always_comb begin
        case (inst_num)
            INST_SH: dmem_wmask = lane[1] ? 4'b1100 : 4'b0011;
            INST_SW: dmem_wmask = 4'b1111;
            default: dmem_wmask = 4'b0000;
        endcase
    end

    // ------------------------------------------------------------------------
    // Load side
    // ------------------------------------------------------------------------
    assign rd_byte = dmem_rdata[{lane, 3'b000} +: 8];

    always_comb begin
        case (inst_num)
            INST_LW:  mem_r = dmem_rdata;
            INST_LBU: mem_r = `ISA_WIDTH'(rd_byte); // zero extended
            default:  mem_r = '0;
        endcase
    end

endmodule

// File: src/exu_pc.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module exu_pc (
    input  rv_pkg::inst_num_e     inst_num,
    input  rv_pkg::inst_type_e    inst_type,
    input  logic [`IMM_WIDTH-1:0] imm,
    input  logic [`ISA_WIDTH-1:0] pc_out,
    input  logic [`ISA_WIDTH-1:0] src1,
    input  logic [`ISA_WIDTH-1:0] alu_result,
    output logic [`ISA_WIDTH-1:0] pc_in,
    output logic                  pc_w_en
);

    import rv_pkg::*;

    logic                  is_jalr;
    logic                  taken;
    logic [`ISA_WIDTH-1:0] adder_a;
    logic [`ISA_WIDTH-1:0] adder_b;
    logic [`ISA_WIDTH-1:0] adder_s;

    assign is_jalr = (inst_num == INST_JALR);
    assign taken   = alu_result[0] && (inst_num inside {INST_BEQ, INST_BNE});

    // ------------------------------------------------------------------------
    // Next-PC adder
    // ------------------------------------------------------------------------
    assign adder_a = is_jalr ? src1 : pc_out;
    assign adder_b = (inst_num == INST_JAL || is_jalr || taken) ? imm : `ISA_WIDTH'd4;
    assign adder_s = adder_a + adder_b;

    // jalr target drops bit 0
    assign pc_in = {adder_s[`ISA_WIDTH-1:1], adder_s[0] & ~is_jalr};

    always_comb begin
        case (inst_type)
            R, I, S, B, U, J: pc_w_en = 1'b1;
            default:          pc_w_en = 1'b0; // unknown word, hold the PC
        endcase
    end

endmodule

// File: src/exu_alu.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module exu_alu (
    input  rv_pkg::inst_num_e     inst_num,
    input  logic [`ISA_WIDTH-1:0] src1,
    input  logic [`ISA_WIDTH-1:0] src2,
    input  logic [`IMM_WIDTH-1:0] imm,
    input  logic [`ISA_WIDTH-1:0] pc,
    output logic [`ISA_WIDTH-1:0] alu_result
);

    import rv_pkg::*;

    logic                  use_imm;
    logic [`ISA_WIDTH-1:0] op_b;

    // I-type arithmetic and address calculation take the immediate
    assign use_imm = inst_num inside {INST_ADDI, INST_SLTIU, INST_ANDI, INST_SRAI,
                                      INST_LW, INST_LBU, INST_SH, INST_SW};
    assign op_b    = use_imm ? imm : src2;

    always_comb begin
        case (inst_num)
            INST_AUIPC:                  alu_result = pc + imm;
            INST_ADD, INST_ADDI,
            INST_LW, INST_LBU,
            INST_SH, INST_SW:            alu_result = src1 + op_b;
            INST_SUB:                    alu_result = src1 - src2;
            INST_SLTU, INST_SLTIU:       alu_result = `ISA_WIDTH'(src1 < op_b);
            INST_ANDI:                   alu_result = src1 & op_b;
            INST_XOR:                    alu_result = src1 ^ src2;
            INST_OR:                     alu_result = src1 | src2;
            INST_SLL:                    alu_result = src1 << op_b[4:0];
            INST_SRAI:                   alu_result = `ISA_WIDTH'($signed(src1) >>> op_b[4:0]);
            // Branch condition in bit 0
            INST_BEQ:                    alu_result = `ISA_WIDTH'(src1 == src2);
            INST_BNE:                    alu_result = `ISA_WIDTH'(src1 != src2);
            default:                     alu_result = '0;
        endcase
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic                  rd_we,
    input  logic [`ISA_WIDTH-1:0] rd_data,
    output logic [`ISA_WIDTH-1:0] src1,
    output logic [`ISA_WIDTH-1:0] src2
);

    logic [`ISA_WIDTH-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin // x0 is never written
            regs[rd] <= rd_data;
        end
    end

    // Asynchronous read
    assign src1 = regs[rs1];
    assign src2 = regs[rs2];

endmodule

// File: src/idu.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module idu (
    input  rv_pkg::rv_inst_u          inst,
    output rv_pkg::inst_num_e         inst_num,
    output rv_pkg::inst_type_e        inst_type,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd,
    output logic [`IMM_WIDTH-1:0]     imm
);

    import rv_pkg::*;

    // Register indices sit at the same place in every format
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    // ------------------------------------------------------------------------
    // Instruction match
    // ------------------------------------------------------------------------
    always_comb begin
        inst_num = INST_NONE;
        case (inst.r.opcode)
            `OP_AUIPC: inst_num = INST_AUIPC;
            `OP_JAL:   inst_num = INST_JAL;
            `OP_JALR: begin
                if (inst.i.funct3 == 3'b000) inst_num = INST_JALR;
            end
            `OP_BRANCH: begin
                case (inst.b.funct3)
                    3'b000:  inst_num = INST_BEQ;
                    3'b001:  inst_num = INST_BNE;
                    default: inst_num = INST_NONE;
                endcase
            end
            `OP_LOAD: begin
                case (inst.i.funct3)
                    3'b010:  inst_num = INST_LW;
                    3'b100:  inst_num = INST_LBU;
                    default: inst_num = INST_NONE;
                endcase
            end
            `OP_STORE: begin
                case (inst.s.funct3)
                    3'b001:  inst_num = INST_SH;
                    3'b010:  inst_num = INST_SW;
                    default: inst_num = INST_NONE;
                endcase
            end
            `OP_IMM: begin
                case (inst.i.funct3)
                    3'b000: inst_num = INST_ADDI;
                    3'b011: inst_num = INST_SLTIU;
                    3'b111: inst_num = INST_ANDI;
                    3'b101: begin
                        if (inst.r.funct7 == 7'b0100000) inst_num = INST_SRAI;
                    end
                    default: inst_num = INST_NONE;
                endcase
            end
            `OP_REG: begin
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: inst_num = INST_ADD;
                    10'b0100000_000: inst_num = INST_SUB;
                    10'b0000000_001: inst_num = INST_SLL;
                    10'b0000000_011: inst_num = INST_SLTU;
                    10'b0000000_100: inst_num = INST_XOR;
                    10'b0000000_110: inst_num = INST_OR;
                    default:         inst_num = INST_NONE;
                endcase
            end
            `OP_SYSTEM: begin
                if (inst.i.imm == 12'h001 && inst.i.rs1 == 5'd0 &&
                    inst.i.funct3 == 3'b000 && inst.i.rd == 5'd0) begin
                    inst_num = INST_EBREAK;
                end
            end
            default: inst_num = INST_NONE;
        endcase
    end

    always_comb begin
        case (inst_num)
            INST_ADD, INST_SUB, INST_SLL, INST_SLTU, INST_XOR, INST_OR: inst_type = R;
            INST_JALR, INST_LW, INST_LBU, INST_ADDI, INST_SLTIU, INST_ANDI,
            INST_SRAI, INST_EBREAK:                                     inst_type = I;
            INST_SH, INST_SW:                                           inst_type = S;
            INST_BEQ, INST_BNE:                                         inst_type = B;
            INST_AUIPC:                                                 inst_type = U;
            INST_JAL:                                                   inst_type = J;
            default:                                                    inst_type = TYPE_NONE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Immediate, built by format and sign extended
    // ------------------------------------------------------------------------
    always_comb begin
        case (inst.r.opcode)
            `OP_LUI, `OP_AUIPC:
                imm = `IMM_WIDTH'($signed({inst.u.imm_31_12, 12'b0}));
            `OP_JAL:
                imm = `IMM_WIDTH'($signed({inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
                                           inst.j.imm_10_1, 1'b0}));
            `OP_BRANCH:
                imm = `IMM_WIDTH'($signed({inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
                                           inst.b.imm_4_1, 1'b0}));
            `OP_STORE:
                imm = `IMM_WIDTH'($signed({inst.s.imm_hi, inst.s.imm_lo}));
            `OP_JALR, `OP_LOAD, `OP_IMM, `OP_SYSTEM:
                imm = `IMM_WIDTH'($signed(inst.i.imm));
            default:
                imm = '0;
        endcase
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    typedef enum logic [4:0] {
        INST_NONE,
        INST_AUIPC, INST_JAL, INST_JALR,
        INST_BEQ, INST_BNE,
        INST_LW, INST_LBU, INST_SH, INST_SW,
        INST_ADDI, INST_SLTIU, INST_ANDI, INST_SRAI,
        INST_ADD, INST_SUB, INST_SLL, INST_SLTU, INST_XOR, INST_OR,
        INST_EBREAK
    } inst_num_e;

    typedef enum logic [2:0] {
        TYPE_NONE, R, I, S, B, U, J
    } inst_type_e;

    // ------------------------------------------------------------------------
    // One view per instruction format, all 32 bits wide
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

endpackage

// File: src/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and immediate widths
`define ISA_WIDTH 32
`define IMM_WIDTH 32

`define RESET_PC 32'h0000_0000

// ------------------------------------------------------------------------
// Base opcodes
// ------------------------------------------------------------------------
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011

`endif
